// File: compile.f
icache_pkg.sv
icache_tag_array.sv
icache_data_array.sv
icache_refill_shim.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

// File: run.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
( verilator --binary --timing --top-module tb_icache -f compile.f -o sim_icache &&
  ./obj_dir/sim_icache ) > sim.log 2>&1 ||
  echo "Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

// File: tb_icache.sv
// Instruction cache testbench
// LFSR driven fetches and flushes against a bus memory model,
// checked with a tag and valid reference model of the direct-mapped cache
`timescale 1ns/1ps

module tb_icache;

  localparam logic [31:0] NC_TOP = 32'h0000_1000;
  localparam int FETCH_TIMEOUT = 64;
  localparam int IDLE_TIMEOUT  = 64;
  localparam int BUS_IDLE  = 0;
  localparam int BUS_GRANT = 1;
  localparam int BUS_DATA  = 2;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        en_i;
  logic        flush_i;
  logic        fetch_req_i;
  logic [31:0] fetch_addr_i;
  logic        busy_o;
  logic        miss_o;
  logic        fetch_valid_o;
  logic [31:0] fetch_data_o;
  logic        bus_rd_req_o;
  logic [31:0] bus_rd_addr_o;
  logic [1:0]  bus_rd_len_o;
  logic        bus_rd_gnt_i;
  logic        bus_rd_valid_i;
  logic [31:0] bus_rd_data_i;
  logic        bus_rd_last_i;

  // Reference model and shared stimulus state
  logic [15:0] lfsr_q;
  logic [15:0] model_valid;
  logic [23:0] model_tag [16];
  int          gnt_delay;
  int          beat_gap [4];
  int          req_count;
  int          exp_reqs;
  logic [31:0] cap_addr;
  logic [1:0]  cap_len;

  always #2 clk_i = ~clk_i;

  icache_top #(
    .NcRegionTop(NC_TOP)
  ) dut0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (en_i),
    .flush_i       (flush_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .busy_o        (busy_o),
    .miss_o        (miss_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_data_o  (fetch_data_o),
    .bus_rd_req_o  (bus_rd_req_o),
    .bus_rd_addr_o (bus_rd_addr_o),
    .bus_rd_len_o  (bus_rd_len_o),
    .bus_rd_gnt_i  (bus_rd_gnt_i),
    .bus_rd_valid_i(bus_rd_valid_i),
    .bus_rd_data_i (bus_rd_data_i),
    .bus_rd_last_i (bus_rd_last_i)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  // Memory content as a function of the word address
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return (a ^ 32'hA5A5_0000) + (a >> 2);
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got=0x%08h exp=0x%08h", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort_run(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("Test failures found");
    $fatal(1, "run aborted");
  endtask

  // Returns at an edge where busy_o was sampled low
  task automatic wait_idle();
    int n;
    n = 0;
    @(posedge clk_i);
    while (busy_o) begin
      n++;
      if (n > IDLE_TIMEOUT) abort_run("busy_o never dropped");
      @(posedge clk_i);
    end
  endtask

  task automatic fetch_word(input logic [31:0] addr, input logic en, output logic missed);
    logic [31:0] waddr;
    logic [3:0]  idx;
    logic [23:0] tag;
    logic        bypass;
    logic        hit;
    int          reqs_before;
    int          cycles;
    int          misses;
    int          b;
    waddr  = {addr[31:2], 2'b00};
    idx    = waddr[7:4];
    tag    = waddr[31:8];
    bypass = !en || (waddr < NC_TOP);
    hit    = !bypass && model_valid[idx] && (model_tag[idx] == tag);
    // Bus timing for this fetch
    gnt_delay = int'(rand_bits(2));
    for (b = 0; b < 4; b++) begin
      beat_gap[b] = int'(rand_bits(2)) % 3;
    end
    wait_idle();
    reqs_before = req_count;
    fetch_req_i  <= 1'b1;
    fetch_addr_i <= waddr;
    en_i         <= en;
    // Accepting edge
    @(posedge clk_i);
    fetch_req_i <= 1'b0;
    cycles = 0;
    misses = 0;
    while (1) begin
      @(posedge clk_i);
      cycles++;
      if (miss_o) misses++;
      if (fetch_valid_o) break;
      if (cycles > FETCH_TIMEOUT) abort_run("fetch_valid_o never came");
    end
    check("miss_o pulses", 32'(misses), hit ? 32'd0 : 32'd1);
    // Sampled one edge after the rise
    if (hit) check("hit latency", 32'(cycles - 1), 32'd2);
    check("fetch_data_o", fetch_data_o, mem_word(waddr));
    check("bus requests", 32'(req_count - reqs_before), hit ? 32'd0 : 32'd1);
    if (!hit) begin
      exp_reqs++;
      check("bus_rd_addr_o", cap_addr, bypass ? waddr : {waddr[31:4], 4'h0});
      check("bus_rd_len_o", 32'(cap_len), bypass ? 32'd0 : 32'd3);
    end
    // Only cacheable misses allocate
    if (!hit && !bypass) begin
      model_valid[idx] = 1'b1;
      model_tag[idx]   = tag;
    end
    // Miss as seen on miss_o
    missed = (misses != 0);
  endtask

  task automatic flush_cache();
    int busy_cycles;
    wait_idle();
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    busy_cycles = 0;
    while (1) begin
      @(posedge clk_i);
      if (!busy_o) break;
      busy_cycles++;
      if (busy_cycles > IDLE_TIMEOUT) abort_run("flush never finished");
    end
    check("flush busy cycles", 32'(busy_cycles), 32'd16);
    model_valid = '0;
  endtask

  // Bus memory, random grant delay and beat gaps
  initial begin : bus_model
    int state;
    int wait_cnt;
    int gap_cnt;
    int beat;
    bus_rd_gnt_i   <= 1'b0;
    bus_rd_valid_i <= 1'b0;
    bus_rd_data_i  <= '0;
    bus_rd_last_i  <= 1'b0;
    state     = BUS_IDLE;
    req_count = 0;
    wait_cnt  = 0;
    gap_cnt   = 0;
    beat      = 0;
    forever begin
      @(posedge clk_i);
      bus_rd_gnt_i   <= 1'b0;
      bus_rd_valid_i <= 1'b0;
      bus_rd_last_i  <= 1'b0;
      case (state)
        BUS_IDLE: begin
          if (rst_ni && bus_rd_req_o) begin
            cap_addr = bus_rd_addr_o;
            cap_len  = bus_rd_len_o;
            req_count++;
            wait_cnt = gnt_delay;
            state    = BUS_GRANT;
          end
        end
        BUS_GRANT: begin
          // Request must hold still until granted
          check("bus_rd_req_o held", 32'(bus_rd_req_o), 32'd1);
          check("bus_rd_addr_o held", bus_rd_addr_o, cap_addr);
          check("bus_rd_len_o held", 32'(bus_rd_len_o), 32'(cap_len));
          wait_cnt--;
        end
        default: begin
          if (gap_cnt > 0) begin
            gap_cnt--;
          end else begin
            bus_rd_valid_i <= 1'b1;
            bus_rd_data_i  <= mem_word(cap_addr + 32'(beat * 4));
            bus_rd_last_i  <= (beat == int'(cap_len));
            if (beat == int'(cap_len)) begin
              state = BUS_IDLE;
            end else begin
              beat++;
              gap_cnt = beat_gap[beat];
            end
          end
        end
      endcase
      // Grant goes out once the delay has run down
      if (state == BUS_GRANT && wait_cnt <= 0) begin
        bus_rd_gnt_i <= 1'b1;
        beat    = 0;
        gap_cnt = beat_gap[0];
        state   = BUS_DATA;
      end
    end
  end

  initial begin : stimulus
    logic        missed;
    logic        en;
    logic [31:0] sel;
    logic [31:0] idx;
    logic [31:0] off;
    int          i;
    rst_ni       <= 1'b0;
    en_i         <= 1'b1;
    flush_i      <= 1'b0;
    fetch_req_i  <= 1'b0;
    fetch_addr_i <= '0;
    lfsr_q      = 16'd17805;
    model_valid = '0;
    exp_reqs    = 0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check("busy_o after reset", 32'(busy_o), 32'd0);
    check("fetch_valid_o after reset", 32'(fetch_valid_o), 32'd0);
    check("miss_o after reset", 32'(miss_o), 32'd0);
    check("bus_rd_req_o after reset", 32'(bus_rd_req_o), 32'd0);

    // Cold line fill, then hits in the same line
    fetch_word(32'h0000_2000, 1'b1, missed);
    fetch_word(32'h0000_2004, 1'b1, missed);
    fetch_word(32'h0000_200C, 1'b1, missed);
    check("hit in filled line", 32'(missed), 32'd0);
    fetch_word(32'h0000_2010, 1'b1, missed);

    // Non-cacheable region reads one word every time
    fetch_word(32'h0000_0104, 1'b1, missed);
    fetch_word(32'h0000_0104, 1'b1, missed);
    check("non-cacheable repeat", 32'(missed), 32'd1);

    // Fetch with the cache off does not allocate
    fetch_word(32'h0000_3024, 1'b0, missed);
    fetch_word(32'h0000_3024, 1'b1, missed);
    check("miss after disabled fetch", 32'(missed), 32'd1);
    fetch_word(32'h0000_3028, 1'b1, missed);
    check("hit after enabled fill", 32'(missed), 32'd0);

    // Everything cached before a flush misses afterwards
    flush_cache();
    fetch_word(32'h0000_2000, 1'b1, missed);
    check("miss after flush", 32'(missed), 32'd1);
    fetch_word(32'h0000_3024, 1'b1, missed);
    check("miss after flush", 32'(missed), 32'd1);

    // Random mix over two low and two cacheable tag regions
    for (i = 0; i < 300; i++) begin
      sel = rand_bits(2);
      idx = rand_bits(4);
      off = rand_bits(2);
      en  = (rand_bits(3) != 32'd0);
      fetch_word((sel << 11) | (idx << 4) | (off << 2), en, missed);
      if (rand_bits(4) == 32'd0) flush_cache();
    end

    wait_idle();
    check("total bus requests", 32'(req_count), 32'(exp_reqs));
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: icache_top.sv
// Instruction cache top level
// Connects the control FSM, tag and data arrays and the bus refill shim
`timescale 1ns/1ps

module icache_top #(
  parameter logic [icache_pkg::ADDR_W-1:0] NcRegionTop = 32'h0000_1000
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            en_i,
  input  logic                            flush_i,
  input  logic                            fetch_req_i,
  input  icache_pkg::fetch_addr_t         fetch_addr_i,
  output logic                            busy_o,
  output logic                            miss_o,
  output logic                            fetch_valid_o,
  output logic [icache_pkg::WORD_W-1:0]   fetch_data_o,
  output logic                            bus_rd_req_o,
  output logic [icache_pkg::ADDR_W-1:0]   bus_rd_addr_o,
  output logic [icache_pkg::OFFSET_W-1:0] bus_rd_len_o,
  input  logic                            bus_rd_gnt_i,
  input  logic                            bus_rd_valid_i,
  input  logic [icache_pkg::WORD_W-1:0]   bus_rd_data_i,
  input  logic                            bus_rd_last_i
);

  // Array side
  logic                            arr_rd_en;
  logic [icache_pkg::INDEX_W-1:0]  arr_index;
  logic [icache_pkg::OFFSET_W-1:0] arr_offset;
  logic                            arr_wr_en;
  logic [icache_pkg::TAG_W-1:0]    arr_wr_tag;
  icache_pkg::line_t               arr_wr_line;
  logic                            inval_en;
  logic [icache_pkg::TAG_W-1:0]    tag_rd_tag;
  logic                            tag_rd_valid;
  logic [icache_pkg::WORD_W-1:0]   data_rd_word;

  // Refill side
  logic                            mem_req;
  icache_pkg::fetch_addr_t         mem_addr;
  logic                            mem_nc;
  logic                            rtrn_valid;
  icache_pkg::line_t               rtrn_line;

  icache_ctrl #(
    .NcRegionTop(NcRegionTop)
  ) i_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (en_i),
    .flush_i       (flush_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .tag_rd_tag_i  (tag_rd_tag),
    .tag_rd_valid_i(tag_rd_valid),
    .data_rd_word_i(data_rd_word),
    .rtrn_valid_i  (rtrn_valid),
    .rtrn_line_i   (rtrn_line),
    .busy_o        (busy_o),
    .miss_o        (miss_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_data_o  (fetch_data_o),
    .arr_rd_en_o   (arr_rd_en),
    .arr_index_o   (arr_index),
    .arr_offset_o  (arr_offset),
    .arr_wr_en_o   (arr_wr_en),
    .arr_wr_tag_o  (arr_wr_tag),
    .arr_wr_line_o (arr_wr_line),
    .inval_en_o    (inval_en),
    .mem_req_o     (mem_req),
    .mem_addr_o    (mem_addr),
    .mem_nc_o      (mem_nc)
  );

  icache_tag_array i_tag_array (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_en_i   (arr_rd_en),
    .index_i   (arr_index),
    .wr_en_i   (arr_wr_en),
    .wr_tag_i  (arr_wr_tag),
    .inval_en_i(inval_en),
    .rd_tag_o  (tag_rd_tag),
    .rd_valid_o(tag_rd_valid)
  );

  icache_data_array i_data_array (
    .clk_i    (clk_i),
    .rd_en_i  (arr_rd_en),
    .index_i  (arr_index),
    .offset_i (arr_offset),
    .wr_en_i  (arr_wr_en),
    .wr_line_i(arr_wr_line),
    .rd_word_o(data_rd_word)
  );

  icache_refill_shim i_refill_shim (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mem_req_i     (mem_req),
    .mem_addr_i    (mem_addr),
    .mem_nc_i      (mem_nc),
    .bus_rd_gnt_i  (bus_rd_gnt_i),
    .bus_rd_valid_i(bus_rd_valid_i),
    .bus_rd_data_i (bus_rd_data_i),
    .bus_rd_last_i (bus_rd_last_i),
    .bus_rd_req_o  (bus_rd_req_o),
    .bus_rd_addr_o (bus_rd_addr_o),
    .bus_rd_len_o  (bus_rd_len_o),
    .rtrn_valid_o  (rtrn_valid),
    .rtrn_line_o   (rtrn_line)
  );

endmodule

// File: icache_ctrl.sv
// Instruction cache control
// Single FSM for lookup, miss and bypass refill, line return and flush sweep
`timescale 1ns/1ps

module icache_ctrl #(
  parameter logic [icache_pkg::ADDR_W-1:0] NcRegionTop = 32'h0000_1000
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            en_i,
  input  logic                            flush_i,
  input  logic                            fetch_req_i,
  input  icache_pkg::fetch_addr_t         fetch_addr_i,
  input  logic [icache_pkg::TAG_W-1:0]    tag_rd_tag_i,
  input  logic                            tag_rd_valid_i,
  input  logic [icache_pkg::WORD_W-1:0]   data_rd_word_i,
  input  logic                            rtrn_valid_i,
  input  icache_pkg::line_t               rtrn_line_i,
  output logic                            busy_o,
  output logic                            miss_o,
  output logic                            fetch_valid_o,
  output logic [icache_pkg::WORD_W-1:0]   fetch_data_o,
  output logic                            arr_rd_en_o,
  output logic [icache_pkg::INDEX_W-1:0]  arr_index_o,
  output logic [icache_pkg::OFFSET_W-1:0] arr_offset_o,
  output logic                            arr_wr_en_o,
  output logic [icache_pkg::TAG_W-1:0]    arr_wr_tag_o,
  output icache_pkg::line_t               arr_wr_line_o,
  output logic                            inval_en_o,
  output logic                            mem_req_o,
  output icache_pkg::fetch_addr_t         mem_addr_o,
  output logic                            mem_nc_o
);

  localparam logic [1:0] IDLE   = 2'd0;
  localparam logic [1:0] LOOKUP = 2'd1;
  localparam logic [1:0] REFILL = 2'd2;
  localparam logic [1:0] FLUSH  = 2'd3;

  logic [1:0]                      state_q;
  logic                            lookup_q;
  logic                            bypass_q;
  logic                            fetch_valid_q;
  logic                            miss_q;
  logic [icache_pkg::INDEX_W-1:0]  flush_cnt_q;
  icache_pkg::fetch_addr_t         addr_q;
  logic [icache_pkg::WORD_W-1:0]   fetch_data_q;
  logic                            fetch_take;
  logic                            flush_take;
  logic                            hit;
  logic [icache_pkg::WORD_W-1:0]   rtrn_word;

  // Busy whenever the FSM is away from IDLE
  assign busy_o     = (state_q != IDLE);
  // Fetch wins over flush in the same cycle
  assign fetch_take = (state_q == IDLE) & fetch_req_i;
  assign flush_take = (state_q == IDLE) & flush_i & ~fetch_req_i;

  // First LOOKUP cycle reads both arrays, bypass skips the read
  assign arr_rd_en_o  = (state_q == LOOKUP) & ~lookup_q & ~bypass_q;
  // Sweep index during flush, fetch index otherwise
  assign arr_index_o  = (state_q == FLUSH) ? flush_cnt_q : addr_q.f.index;
  assign arr_offset_o = addr_q.f.offset;
  assign inval_en_o   = (state_q == FLUSH);

  // Second LOOKUP cycle compares the stored tag
  assign hit = (state_q == LOOKUP) & lookup_q & ~bypass_q & tag_rd_valid_i &
               (tag_rd_tag_i == addr_q.f.tag);

  // Allocate on the returned line unless the access was a bypass
  assign arr_wr_en_o   = (state_q == REFILL) & rtrn_valid_i & ~bypass_q;
  assign arr_wr_tag_o  = addr_q.f.tag;
  assign arr_wr_line_o = rtrn_line_i;

  // Single-word reads land in word 0
  assign rtrn_word = bypass_q ? rtrn_line_i[0] : rtrn_line_i[addr_q.f.offset];

  // Bus request pulse shares the miss pulse
  assign mem_req_o  = miss_q;
  assign mem_addr_o = addr_q;
  assign mem_nc_o   = bypass_q;

  assign miss_o        = miss_q;
  assign fetch_valid_o = fetch_valid_q;
  assign fetch_data_o  = fetch_data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      lookup_q      <= 1'b0;
      bypass_q      <= 1'b0;
      fetch_valid_q <= 1'b0;
      miss_q        <= 1'b0;
      flush_cnt_q   <= '0;
    end else begin
      fetch_valid_q <= 1'b0;
      miss_q        <= 1'b0;
      case (state_q)
        IDLE: begin
          if (fetch_take) begin
            state_q  <= LOOKUP;
            lookup_q <= 1'b0;
            // Cache off or low region goes straight to the bus
            bypass_q <= ~en_i | (fetch_addr_i.raw < NcRegionTop);
          end else if (flush_take) begin
            state_q     <= FLUSH;
            flush_cnt_q <= '0;
          end
        end
        LOOKUP: begin
          lookup_q <= 1'b1;
          if (lookup_q) begin
            if (hit) begin
              fetch_valid_q <= 1'b1;
              state_q       <= IDLE;
            end else begin
              miss_q  <= 1'b1;
              state_q <= REFILL;
            end
          end
        end
        REFILL: begin
          if (rtrn_valid_i) begin
            fetch_valid_q <= 1'b1;
            state_q       <= IDLE;
          end
        end
        default: begin
          // One set cleared per cycle, 16 cycles in total
          flush_cnt_q <= flush_cnt_q + 1'b1;
          if (flush_cnt_q == icache_pkg::INDEX_W'(icache_pkg::NUM_SETS - 1)) begin
            state_q <= IDLE;
          end
        end
      endcase
    end
  end

  // Fetch address and returned word
  always_ff @(posedge clk_i) begin
    if (fetch_take) begin
      addr_q <= fetch_addr_i;
    end
    if (hit) begin
      fetch_data_q <= data_rd_word_i;
    end else if ((state_q == REFILL) && rtrn_valid_i) begin
      fetch_data_q <= rtrn_word;
    end
  end

endmodule

// File: icache_refill_shim.sv
// Instruction cache refill shim
// Holds the read request until grant, picks line burst or single word,
// and assembles the returned beats into a line
`timescale 1ns/1ps

module icache_refill_shim (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            mem_req_i,
  input  icache_pkg::fetch_addr_t         mem_addr_i,
  input  logic                            mem_nc_i,
  input  logic                            bus_rd_gnt_i,
  input  logic                            bus_rd_valid_i,
  input  logic [icache_pkg::WORD_W-1:0]   bus_rd_data_i,
  input  logic                            bus_rd_last_i,
  output logic                            bus_rd_req_o,
  output logic [icache_pkg::ADDR_W-1:0]   bus_rd_addr_o,
  output logic [icache_pkg::OFFSET_W-1:0] bus_rd_len_o,
  output logic                            rtrn_valid_o,
  output icache_pkg::line_t               rtrn_line_o
);

  logic                            req_valid_q;
  icache_pkg::fetch_addr_t         addr_d;
  icache_pkg::fetch_addr_t         addr_q;
  logic [icache_pkg::OFFSET_W-1:0] len_q;
  logic                            first_q;
  icache_pkg::line_t               shift_d;
  icache_pkg::line_t               shift_q;

  // Word address always, line aligned for a fill
  always_comb begin
    addr_d            = mem_addr_i;
    addr_d.f.byte_off = '0;
    if (!mem_nc_i) begin
      addr_d.f.offset = '0;
    end
  end

  // Request stays up until the grant cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else if (mem_req_i) begin
      req_valid_q <= 1'b1;
    end else if (bus_rd_gnt_i) begin
      req_valid_q <= 1'b0;
    end
  end

  // Address and beat count, stable while the request is pending
  always_ff @(posedge clk_i) begin
    if (mem_req_i) begin
      addr_q <= addr_d;
      len_q  <= mem_nc_i ? '0 : icache_pkg::OFFSET_W'(icache_pkg::LINE_WORDS - 1);
    end
  end

  assign bus_rd_req_o  = req_valid_q;
  assign bus_rd_addr_o = addr_q.raw;
  assign bus_rd_len_o  = len_q;

  // New beats enter at the top and move down
  always_comb begin
    shift_d = shift_q;
    if (bus_rd_valid_i) begin
      shift_d = {bus_rd_data_i, shift_q[icache_pkg::LINE_WORDS-1:1]};
      // First beat also goes to word 0 so a single read ends up there
      if (first_q) begin
        shift_d[0] = bus_rd_data_i;
      end
    end
  end

  // Next beat after a last beat starts a new transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q <= 1'b1;
    end else if (bus_rd_valid_i) begin
      first_q <= bus_rd_last_i;
    end
  end

  always_ff @(posedge clk_i) begin
    shift_q <= shift_d;
  end

  // Line goes back together with the last beat
  assign rtrn_valid_o = bus_rd_valid_i & bus_rd_last_i;
  assign rtrn_line_o  = shift_d;

endmodule

// File: icache_data_array.sv
// Instruction cache data array
// Whole-line storage per set, written on refill,
// read one cycle later with the requested word selected
`timescale 1ns/1ps

module icache_data_array (
  input  logic                            clk_i,
  input  logic                            rd_en_i,
  input  logic [icache_pkg::INDEX_W-1:0]  index_i,
  input  logic [icache_pkg::OFFSET_W-1:0] offset_i,
  input  logic                            wr_en_i,
  input  icache_pkg::line_t               wr_line_i,
  output logic [icache_pkg::WORD_W-1:0]   rd_word_o
);

  icache_pkg::line_t line_mem [icache_pkg::NUM_SETS];

  always_ff @(posedge clk_i) begin
    // Refill stores all words of the line at once
    if (wr_en_i) begin
      line_mem[index_i] <= wr_line_i;
    end
    // Word select done on the read port
    if (rd_en_i) begin
      rd_word_o <= line_mem[index_i][offset_i];
    end
  end

endmodule

// File: icache_tag_array.sv
// Instruction cache tag array
// One tag and valid bit per set, synchronous read,
// set on allocation and cleared one set at a time by the flush sweep
`timescale 1ns/1ps

module icache_tag_array (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           rd_en_i,
  input  logic [icache_pkg::INDEX_W-1:0] index_i,
  input  logic                           wr_en_i,
  input  logic [icache_pkg::TAG_W-1:0]   wr_tag_i,
  input  logic                           inval_en_i,
  output logic [icache_pkg::TAG_W-1:0]   rd_tag_o,
  output logic                           rd_valid_o
);

  logic [icache_pkg::TAG_W-1:0]    tag_mem [icache_pkg::NUM_SETS];
  logic [icache_pkg::NUM_SETS-1:0] valid_q;

  // Valid bits start cleared so nothing hits after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      rd_valid_o <= 1'b0;
    end else begin
      if (wr_en_i) begin
        valid_q[index_i] <= 1'b1;
      end else if (inval_en_i) begin
        valid_q[index_i] <= 1'b0;
      end
      if (rd_en_i) begin
        rd_valid_o <= valid_q[index_i];
      end
    end
  end

  // Tag storage, compare happens in the controller
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      tag_mem[index_i] <= wr_tag_i;
    end
    if (rd_en_i) begin
      rd_tag_o <= tag_mem[index_i];
    end
  end

endmodule

// File: icache_pkg.sv
// Instruction cache shared definitions
// Address, word and line geometry of the direct-mapped cache,
// plus the fetch address that is decoded both as a raw byte address and as lookup fields
package icache_pkg;

  // Bus and instruction widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // Line geometry
  localparam int LINE_WORDS = 4;
  localparam int OFFSET_W   = 2;
  localparam int INDEX_W    = 4;
  localparam int NUM_SETS   = 16;

  // Byte bits inside one 32-bit word
  localparam int BYTE_OFF_W = 2;

  // Remaining upper address bits form the tag
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;

  // One cache line, word 0 sits in the low bits
  typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

  // Lookup view of a fetch address, MSB first
  typedef struct packed {
    logic [TAG_W-1:0]      tag;
    logic [INDEX_W-1:0]    index;
    logic [OFFSET_W-1:0]   offset;
    logic [BYTE_OFF_W-1:0] byte_off;
  } fetch_fields_t;

  // Same word seen two ways
  // raw for region compare and bus address, f for tag/index/offset
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    fetch_fields_t     f;
  } fetch_addr_t;

endpackage
